// File: include/axi_memory_defines.svh
// memory map and latency; DRAM size must be a power of two of at least 4 bytes, delay at least 1
`ifndef AXI_MEMORY_DEFINES_SVH
`define AXI_MEMORY_DEFINES_SVH

// word organized DRAM window
`define AXI_MEMORY_DRAM_BASE 32'h8000_0000
`define AXI_MEMORY_DRAM_SIZE 4096

// UART0 transmit register window
`define AXI_MEMORY_UART0_BASE 32'h1000_0000
`define AXI_MEMORY_UART0_SIZE 256

// cycles from the accept edge to the response edge
`define AXI_MEMORY_DELAY 5

`endif

// File: source/axi_memory_pkg.sv
// channel payloads and address decode; decode ranges are base inclusive, base plus size exclusive
`default_nettype none
`include "axi_memory_defines.svh"

package axi_memory_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2,
    DECERR = 2'd3
  } resp_e;

  typedef enum logic [1:0] {
    DEV_DRAM,
    DEV_UART0,
    DEV_NONE
  } device_e;

  // word index into the DRAM array
  typedef logic [$clog2(`AXI_MEMORY_DRAM_SIZE / 4) - 1:0] index_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  prot;
  } axi_ar_t;

  typedef struct packed {
    logic [31:0] data;
    resp_e       resp;
  } axi_r_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  prot;
  } axi_aw_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
  } axi_w_t;

  function automatic device_e device_of(input logic [31:0] addr);
    logic [32:0] a;
    a = {1'b0, addr};
    if (a >= 33'(`AXI_MEMORY_DRAM_BASE) &&
        a < 33'(`AXI_MEMORY_DRAM_BASE) + 33'(`AXI_MEMORY_DRAM_SIZE)) begin
      return DEV_DRAM;
    end
    if (a >= 33'(`AXI_MEMORY_UART0_BASE) &&
        a < 33'(`AXI_MEMORY_UART0_BASE) + 33'(`AXI_MEMORY_UART0_SIZE)) begin
      return DEV_UART0;
    end
    return DEV_NONE;
  endfunction

  // bits 1:0 dropped, only meaningful for DRAM addresses
  function automatic index_t index_of(input logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - 32'(`AXI_MEMORY_DRAM_BASE);
    return offset[$bits(index_t) + 1:2];
  endfunction

endpackage

`default_nettype wire

// File: source/byte_store.sv
// DRAM words are not initialized; reads are combinational so a same-edge write is not seen
`default_nettype none
`include "axi_memory_defines.svh"

module byte_store (
  input  logic                   aclk,
  input  axi_memory_pkg::index_t i_a_index,
  input  axi_memory_pkg::index_t i_b_index,
  output logic [31:0]            o_a_word,
  output logic [31:0]            o_b_word,
  input  logic                   i_wr_en,
  input  axi_memory_pkg::index_t i_wr_index,
  input  logic [31:0]            i_wr_data,
  input  logic [3:0]             i_wr_strb
);

  localparam int WORDS = `AXI_MEMORY_DRAM_SIZE / 4;

  logic [31:0] mem [WORDS];

  assign o_a_word = mem[i_a_index];
  assign o_b_word = mem[i_b_index];

  // byte lanes follow the strobe
  always_ff @(posedge aclk) begin
    if (i_wr_en) begin
      for (int i = 0; i < 4; i++) begin
        if (i_wr_strb[i]) begin
          mem[i_wr_index][8*i +: 8] <= i_wr_data[8*i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/read_port.sv
// single outstanding read with fixed latency; prot is ignored, data sampled on the rvalid edge
`default_nettype none
`include "axi_memory_defines.svh"

module read_port (
  input  logic                    aclk,
  input  logic                    areset,
  input  axi_memory_pkg::axi_ar_t i_ar,
  input  logic                    i_arvalid,
  output logic                    o_arready,
  output axi_memory_pkg::axi_r_t  o_r,
  output logic                    o_rvalid,
  input  logic                    i_rready,
  output axi_memory_pkg::index_t  o_index,
  input  logic [31:0]             i_word
);

  localparam int CNT_W = $clog2(`AXI_MEMORY_DELAY + 1);

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    RESP
  } state_e;

  state_e           state;
  logic [CNT_W-1:0] cnt;
  logic [31:0]      addr_q;
  logic             last_wait;

  assign o_arready = (state == IDLE);
  assign o_rvalid  = (state == RESP);
  assign last_wait = (state == WAIT) && (cnt == '0);
  assign o_index   = axi_memory_pkg::index_of(addr_q);

  always_ff @(posedge aclk) begin
    if (areset) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (i_arvalid) begin
            state <= WAIT;
            cnt   <= CNT_W'(`AXI_MEMORY_DELAY - 1);
          end
        end
        WAIT: begin
          if (cnt == '0) begin
            state <= RESP;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        RESP: begin
          if (i_rready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // payload held until the R transfer
  always_ff @(posedge aclk) begin
    if (o_arready && i_arvalid) begin
      addr_q <= i_ar.addr;
    end
    if (last_wait) begin
      case (axi_memory_pkg::device_of(addr_q))
        axi_memory_pkg::DEV_DRAM:  o_r <= '{data: i_word, resp: axi_memory_pkg::OKAY};
        axi_memory_pkg::DEV_UART0: o_r <= '{data: 32'd0, resp: axi_memory_pkg::OKAY};
        default:                   o_r <= '{data: 32'd0, resp: axi_memory_pkg::DECERR};
      endcase
    end
  end

  a_r_hold: assert property (@(posedge aclk) disable iff (areset)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_r))
    else $error("read response changed before rready");

  a_latency: assert property (@(posedge aclk) disable iff (areset)
    o_arready && i_arvalid |-> ##(`AXI_MEMORY_DELAY + 1) $rose(o_rvalid))
    else $error("rvalid did not rise after the fixed latency");

endmodule

`default_nettype wire

// File: source/write_port.sv
// single outstanding write; AW and W may arrive in any order, prot ignored, uart needs strobe bit 0
`default_nettype none
`include "axi_memory_defines.svh"

module write_port (
  input  logic                    aclk,
  input  logic                    areset,
  input  axi_memory_pkg::axi_aw_t i_aw,
  input  logic                    i_awvalid,
  output logic                    o_awready,
  input  axi_memory_pkg::axi_w_t  i_w,
  input  logic                    i_wvalid,
  output logic                    o_wready,
  output axi_memory_pkg::resp_e   o_bresp,
  output logic                    o_bvalid,
  input  logic                    i_bready,
  output logic                    o_wr_en,
  output axi_memory_pkg::index_t  o_wr_index,
  output logic [31:0]             o_wr_data,
  output logic [3:0]              o_wr_strb,
  output logic                    o_uart_valid,
  output logic [7:0]              o_uart_byte
);

  localparam int CNT_W = $clog2(`AXI_MEMORY_DELAY + 1);

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    RESP
  } state_e;

  state_e                  state;
  logic [CNT_W-1:0]        cnt;
  logic                    aw_held;
  logic                    w_held;
  logic                    aw_fire;
  logic                    w_fire;
  logic                    commit;
  logic [31:0]             aw_addr_q;
  logic [31:0]             w_data_q;
  logic [3:0]              w_strb_q;
  axi_memory_pkg::device_e dev;

  assign o_awready = !aw_held;
  assign o_wready  = !w_held;
  assign aw_fire   = i_awvalid && o_awready;
  assign w_fire    = i_wvalid && o_wready;
  assign o_bvalid  = (state == RESP);
  assign commit    = (state == WAIT) && (cnt == '0);
  assign dev       = axi_memory_pkg::device_of(aw_addr_q);

  // store write lands on the commit edge
  assign o_wr_en    = commit && (dev == axi_memory_pkg::DEV_DRAM);
  assign o_wr_index = axi_memory_pkg::index_of(aw_addr_q);
  assign o_wr_data  = w_data_q;
  assign o_wr_strb  = w_strb_q;

  always_ff @(posedge aclk) begin
    if (areset) begin
      state        <= IDLE;
      cnt          <= '0;
      aw_held      <= 1'b0;
      w_held       <= 1'b0;
      o_uart_valid <= 1'b0;
    end else begin
      o_uart_valid <= commit && (dev == axi_memory_pkg::DEV_UART0) && w_strb_q[0];
      if (aw_fire) begin
        aw_held <= 1'b1;
      end
      if (w_fire) begin
        w_held <= 1'b1;
      end
      case (state)
        IDLE: begin
          // latency starts from the later of the two accepts
          if ((aw_held || aw_fire) && (w_held || w_fire)) begin
            state <= WAIT;
            cnt   <= CNT_W'(`AXI_MEMORY_DELAY - 1);
          end
        end
        WAIT: begin
          if (cnt == '0) begin
            state <= RESP;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        RESP: begin
          if (i_bready) begin
            state   <= IDLE;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (aw_fire) begin
      aw_addr_q <= i_aw.addr;
    end
    if (w_fire) begin
      w_data_q <= i_w.data;
      w_strb_q <= i_w.strb;
    end
    if (commit) begin
      o_bresp     <= (dev == axi_memory_pkg::DEV_NONE) ? axi_memory_pkg::DECERR
                                                       : axi_memory_pkg::OKAY;
      o_uart_byte <= w_data_q[7:0];
    end
  end

  a_b_hold: assert property (@(posedge aclk) disable iff (areset)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp))
    else $error("write response changed before bready");

  a_one_target: assert property (@(posedge aclk) disable iff (areset)
    !(o_wr_en && o_uart_valid))
    else $error("store write and uart output together");

endmodule

`default_nettype wire

// File: source/axi_memory.sv
// simulation memory model with two read ports and one write port sharing one DRAM array
`default_nettype none

module axi_memory (
  input  logic                    aclk,
  input  logic                    areset,

  // port A for instruction fetch
  input  axi_memory_pkg::axi_ar_t i_a_ar,
  input  logic                    i_a_arvalid,
  output logic                    o_a_arready,
  output axi_memory_pkg::axi_r_t  o_a_r,
  output logic                    o_a_rvalid,
  input  logic                    i_a_rready,

  // port B for data load
  input  axi_memory_pkg::axi_ar_t i_b_ar,
  input  logic                    i_b_arvalid,
  output logic                    o_b_arready,
  output axi_memory_pkg::axi_r_t  o_b_r,
  output logic                    o_b_rvalid,
  input  logic                    i_b_rready,

  // write port
  input  axi_memory_pkg::axi_aw_t i_aw,
  input  logic                    i_awvalid,
  output logic                    o_awready,
  input  axi_memory_pkg::axi_w_t  i_w,
  input  logic                    i_wvalid,
  output logic                    o_wready,
  output axi_memory_pkg::resp_e   o_bresp,
  output logic                    o_bvalid,
  input  logic                    i_bready,

  output logic                    o_uart_valid,
  output logic [7:0]              o_uart_byte
);

  axi_memory_pkg::index_t a_index;
  axi_memory_pkg::index_t b_index;
  axi_memory_pkg::index_t wr_index;
  logic [31:0]            a_word;
  logic [31:0]            b_word;
  logic                   wr_en;
  logic [31:0]            wr_data;
  logic [3:0]             wr_strb;

  read_port read_port_a (
    .aclk      (aclk),
    .areset    (areset),
    .i_ar      (i_a_ar),
    .i_arvalid (i_a_arvalid),
    .o_arready (o_a_arready),
    .o_r       (o_a_r),
    .o_rvalid  (o_a_rvalid),
    .i_rready  (i_a_rready),
    .o_index   (a_index),
    .i_word    (a_word)
  );

  read_port read_port_b (
    .aclk      (aclk),
    .areset    (areset),
    .i_ar      (i_b_ar),
    .i_arvalid (i_b_arvalid),
    .o_arready (o_b_arready),
    .o_r       (o_b_r),
    .o_rvalid  (o_b_rvalid),
    .i_rready  (i_b_rready),
    .o_index   (b_index),
    .i_word    (b_word)
  );

  write_port write_port (
    .aclk         (aclk),
    .areset       (areset),
    .i_aw         (i_aw),
    .i_awvalid    (i_awvalid),
    .o_awready    (o_awready),
    .i_w          (i_w),
    .i_wvalid     (i_wvalid),
    .o_wready     (o_wready),
    .o_bresp      (o_bresp),
    .o_bvalid     (o_bvalid),
    .i_bready     (i_bready),
    .o_wr_en      (wr_en),
    .o_wr_index   (wr_index),
    .o_wr_data    (wr_data),
    .o_wr_strb    (wr_strb),
    .o_uart_valid (o_uart_valid),
    .o_uart_byte  (o_uart_byte)
  );

  byte_store byte_store (
    .aclk       (aclk),
    .i_a_index  (a_index),
    .i_b_index  (b_index),
    .o_a_word   (a_word),
    .o_b_word   (b_word),
    .i_wr_en    (wr_en),
    .i_wr_index (wr_index),
    .i_wr_data  (wr_data),
    .i_wr_strb  (wr_strb)
  );

endmodule

`default_nettype wire

// File: sim/tb_axi_memory.sv
// self-checking testbench; only DRAM words written earlier are read back, stimulus from a seeded LFSR
`default_nettype none
`include "axi_memory_defines.svh"

module tb_axi_memory;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CH_A = 0;
  localparam int CH_B = 1;
  localparam int CH_AW = 2;
  localparam int CH_W = 3;
  localparam int CH_AWW = 4;
  localparam int CH_WR = 5;
  localparam int IDX_W = $clog2(`AXI_MEMORY_DRAM_SIZE / 4);

  logic                    aclk = 1'b0;
  logic                    areset;
  axi_memory_pkg::axi_ar_t i_a_ar;
  logic                    i_a_arvalid;
  logic                    o_a_arready;
  axi_memory_pkg::axi_r_t  o_a_r;
  logic                    o_a_rvalid;
  logic                    i_a_rready;
  axi_memory_pkg::axi_ar_t i_b_ar;
  logic                    i_b_arvalid;
  logic                    o_b_arready;
  axi_memory_pkg::axi_r_t  o_b_r;
  logic                    o_b_rvalid;
  logic                    i_b_rready;
  axi_memory_pkg::axi_aw_t i_aw;
  logic                    i_awvalid;
  logic                    o_awready;
  axi_memory_pkg::axi_w_t  i_w;
  logic                    i_wvalid;
  logic                    o_wready;
  axi_memory_pkg::resp_e   o_bresp;
  logic                    o_bvalid;
  logic                    i_bready;
  logic                    o_uart_valid;
  logic [7:0]              o_uart_byte;

  logic [15:0]             lfsr = 16'd37453;
  logic [31:0]             ref_mem [int];
  int                      pool [8];
  axi_memory_pkg::axi_r_t  exp_a [$];
  axi_memory_pkg::axi_r_t  exp_b [$];
  axi_memory_pkg::resp_e   exp_bresp [$];
  logic [7:0]              exp_uart [$];
  bit                      r_hold [2];
  axi_memory_pkg::axi_r_t  r_prev [2];
  bit                      b_hold;
  axi_memory_pkg::resp_e   b_prev;

  axi_memory i_axi_memory (.*);

  always #50 aclk = ~aclk;

  // taps 16, 14, 13, 11
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic axi_memory_pkg::device_e region_of(input logic [31:0] a);
    longint unsigned x;
    x = a;
    if (x >= 64'(`AXI_MEMORY_DRAM_BASE) &&
        x < 64'(`AXI_MEMORY_DRAM_BASE) + 64'(`AXI_MEMORY_DRAM_SIZE)) begin
      return axi_memory_pkg::DEV_DRAM;
    end
    if (x >= 64'(`AXI_MEMORY_UART0_BASE) &&
        x < 64'(`AXI_MEMORY_UART0_BASE) + 64'(`AXI_MEMORY_UART0_SIZE)) begin
      return axi_memory_pkg::DEV_UART0;
    end
    return axi_memory_pkg::DEV_NONE;
  endfunction

  function automatic int word_of(input logic [31:0] a);
    return int'((a - 32'(`AXI_MEMORY_DRAM_BASE)) >> 2);
  endfunction

  function automatic logic [31:0] word_addr(input int idx);
    return 32'(`AXI_MEMORY_DRAM_BASE) + 32'(idx) * 32'd4;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] r;
    r = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        r[8*i +: 8] = data[8*i +: 8];
      end
    end
    return r;
  endfunction

  function automatic axi_memory_pkg::axi_r_t expected_r(input logic [31:0] a);
    axi_memory_pkg::axi_r_t r;
    r.data = 32'd0;
    r.resp = axi_memory_pkg::OKAY;
    case (region_of(a))
      axi_memory_pkg::DEV_DRAM:  r.data = ref_mem[word_of(a)];
      axi_memory_pkg::DEV_UART0: r.data = 32'd0;
      default:                   r.resp = axi_memory_pkg::DECERR;
    endcase
    return r;
  endfunction

  function automatic axi_memory_pkg::resp_e expected_b(input logic [31:0] a);
    if (region_of(a) == axi_memory_pkg::DEV_NONE) begin
      return axi_memory_pkg::DECERR;
    end
    return axi_memory_pkg::OKAY;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_r(input string name, input axi_memory_pkg::axi_r_t got,
                         input axi_memory_pkg::axi_r_t exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_b(input string name, input axi_memory_pkg::resp_e got,
                         input axi_memory_pkg::resp_e exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_uart(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_flags(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic next_cycle();
    @(posedge aclk);
    #10;
  endtask

  function automatic logic ready_of(input int ch);
    case (ch)
      CH_A:    return o_a_arready;
      CH_B:    return o_b_arready;
      CH_AW:   return o_awready;
      CH_W:    return o_wready;
      default: return o_awready && o_wready;
    endcase
  endfunction

  function automatic logic valid_of(input int ch);
    case (ch)
      CH_A:    return o_a_rvalid;
      CH_B:    return o_b_rvalid;
      default: return o_bvalid;
    endcase
  endfunction

  task automatic set_ready(input int ch, input logic v);
    case (ch)
      CH_A:    i_a_rready = v;
      CH_B:    i_b_rready = v;
      default: i_bready = v;
    endcase
  endtask

  // returns one cycle past the accept edge
  task automatic wait_accept(input int ch);
    int n;
    n = 0;
    while (!ready_of(ch)) begin
      next_cycle();
      n++;
      if (n >= 100) begin
        abort_run($sformatf("timed out waiting for ready on channel %0d", ch));
      end
    end
    next_cycle();
  endtask

  // rise counts cycles from the accept edge to the first valid
  task automatic wait_response(input int ch, input bit gaps, output int rise);
    int   n;
    logic ready;
    bit   done;
    n    = 0;
    rise = -1;
    done = 1'b0;
    while (!done) begin
      ready = gaps ? (take_bits(1) != 0) : 1'b1;
      set_ready(ch, ready);
      if (valid_of(ch) && rise < 0) begin
        rise = n;
      end
      if (valid_of(ch) && ready) begin
        done = 1'b1;
      end
      next_cycle();
      n++;
      if (!done && n >= 100) begin
        abort_run($sformatf("timed out waiting for a response on channel %0d", ch));
      end
    end
    set_ready(ch, 1'b0);
  endtask

  task automatic read_addr(input int port, input logic [31:0] a, input bit gaps);
    int rise;
    if (port == CH_A) begin
      exp_a.push_back(expected_r(a));
      i_a_ar      = '{addr: a, prot: 3'd0};
      i_a_arvalid = 1'b1;
    end else begin
      exp_b.push_back(expected_r(a));
      i_b_ar      = '{addr: a, prot: 3'd0};
      i_b_arvalid = 1'b1;
    end
    wait_accept(port);
    if (port == CH_A) begin
      i_a_arvalid = 1'b0;
    end else begin
      i_b_arvalid = 1'b0;
    end
    wait_response(port, gaps, rise);
    if (!gaps && rise != `AXI_MEMORY_DELAY) begin
      abort_run($sformatf("read on port %0d answered after %0d cycles instead of %0d",
                          port, rise, `AXI_MEMORY_DELAY));
    end
  endtask

  // aw_lead is how many cycles AW is accepted before W
  task automatic write_word(input logic [31:0] a, input logic [31:0] data,
                            input logic [3:0] strb, input int aw_lead, input bit gaps);
    int rise;
    exp_bresp.push_back(expected_b(a));
    if (region_of(a) == axi_memory_pkg::DEV_UART0 && strb[0]) begin
      exp_uart.push_back(data[7:0]);
    end
    if (region_of(a) == axi_memory_pkg::DEV_DRAM) begin
      ref_mem[word_of(a)] = merge_bytes(ref_mem.exists(word_of(a)) ? ref_mem[word_of(a)] : 'x,
                                        data, strb);
    end
    i_aw      = '{addr: a, prot: 3'd0};
    i_awvalid = 1'b1;
    if (aw_lead > 0) begin
      wait_accept(CH_AW);
      i_awvalid = 1'b0;
      repeat (aw_lead - 1) next_cycle();
    end
    i_w      = '{data: data, strb: strb};
    i_wvalid = 1'b1;
    wait_accept(aw_lead > 0 ? CH_W : CH_AWW);
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
    wait_response(CH_WR, gaps, rise);
    if (!gaps && rise != `AXI_MEMORY_DELAY) begin
      abort_run($sformatf("write answered after %0d cycles instead of %0d",
                          rise, `AXI_MEMORY_DELAY));
    end
  endtask

  task automatic verify_pool();
    for (int i = 0; i < 8; i++) begin
      read_addr(i % 2, word_addr(pool[i]), 1'b0);
    end
  endtask

  task automatic observe_r(input int p, input string name, input logic valid, input logic ready,
                           input axi_memory_pkg::axi_r_t r);
    axi_memory_pkg::axi_r_t exp;
    if (r_hold[p]) begin
      if (!valid) begin
        abort_run($sformatf("rvalid on port %0d dropped before rready", p));
      end
      check_r({name, " held"}, r, r_prev[p]);
    end
    if (valid && ready) begin
      if ((p == CH_A && exp_a.size() == 0) || (p == CH_B && exp_b.size() == 0)) begin
        abort_run($sformatf("read response on port %0d that nobody asked for", p));
      end
      if (p == CH_A) begin
        exp = exp_a.pop_front();
      end else begin
        exp = exp_b.pop_front();
      end
      check_r(name, r, exp);
    end
    r_hold[p] = valid && !ready;
    r_prev[p] = r;
  endtask

  task automatic observe_b();
    if (b_hold) begin
      if (!o_bvalid) begin
        abort_run("bvalid dropped before bready");
      end
      check_b("o_bresp held", o_bresp, b_prev);
    end
    if (o_bvalid && i_bready) begin
      if (exp_bresp.size() == 0) begin
        abort_run("write response that nobody asked for");
      end
      check_b("o_bresp", o_bresp, exp_bresp.pop_front());
    end
    b_hold = o_bvalid && !i_bready;
    b_prev = o_bresp;
  endtask

  // transfers happen on the next rising edge, inputs settle 10 ns after the previous one
  always @(negedge aclk) begin
    if (!areset) begin
      observe_r(CH_A, "o_a_r", o_a_rvalid, i_a_rready, o_a_r);
      observe_r(CH_B, "o_b_r", o_b_rvalid, i_b_rready, o_b_r);
      observe_b();
      if (o_uart_valid) begin
        if (exp_uart.size() == 0) begin
          abort_run("UART pulse without a matching UART0 write");
        end
        check_uart("o_uart_byte", o_uart_byte, exp_uart.pop_front());
      end
    end
  end

  initial begin
    int          idx;
    logic [31:0] a0;
    logic [31:0] a1;
    areset      = 1'b1;
    i_a_ar      = '0;
    i_a_arvalid = 1'b0;
    i_a_rready  = 1'b0;
    i_b_ar      = '0;
    i_b_arvalid = 1'b0;
    i_b_rready  = 1'b0;
    i_aw        = '0;
    i_awvalid   = 1'b0;
    i_w         = '0;
    i_wvalid    = 1'b0;
    i_bready    = 1'b0;
    repeat (2) @(posedge aclk);
    #10;
    areset = 1'b0;
    check_flags("handshake outputs after reset",
                {o_a_arready, o_b_arready, o_awready, o_wready,
                 o_a_rvalid, o_b_rvalid, o_bvalid, o_uart_valid}, 8'hf0);

    // basic write and read on both ports
    write_word(word_addr(4), 32'hdead_beef, 4'hf, 0, 1'b0);
    read_addr(CH_A, word_addr(4), 1'b0);
    read_addr(CH_B, word_addr(4), 1'b0);

    // index 0 is where UART0 and low unmapped addresses would alias
    pool[0] = 0;
    for (int i = 1; i < 8; i++) begin
      pool[i] = int'(take_bits(IDX_W));
    end
    for (int i = 0; i < 8; i++) begin
      write_word(word_addr(pool[i]), take_bits(32), 4'hf, 0, 1'b0);
    end
    for (int i = 0; i < 40; i++) begin
      idx = pool[take_bits(3)];
      write_word(word_addr(idx), take_bits(32), take_bits(4), 0, 1'b0);
      read_addr(int'(take_bits(1)), word_addr(idx) | take_bits(2), 1'b0);
    end

    write_word(32'(`AXI_MEMORY_UART0_BASE), 32'h1234_5641, 4'h1, 0, 1'b0);
    write_word(32'(`AXI_MEMORY_UART0_BASE) + 32'd4, 32'h0000_0042, 4'he, 0, 1'b0);
    verify_pool();
    read_addr(CH_B, 32'(`AXI_MEMORY_UART0_BASE) + 32'd8, 1'b0);

    write_word(32'h0000_1000, 32'hffff_ffff, 4'hf, 0, 1'b0);
    verify_pool();
    read_addr(CH_A, 32'h0000_1000, 1'b0);
    read_addr(CH_B, 32'(`AXI_MEMORY_DRAM_BASE) + 32'(`AXI_MEMORY_DRAM_SIZE), 1'b0);

    // both read ports in flight together
    a0 = word_addr(pool[1]);
    a1 = word_addr(pool[2]);
    fork
      read_addr(CH_A, a0, 1'b0);
      read_addr(CH_B, a1, 1'b0);
    join
    for (int i = 0; i < 12; i++) begin
      write_word(word_addr(pool[take_bits(3)]), take_bits(32), take_bits(4), 0, 1'b1);
      a0 = word_addr(pool[take_bits(3)]);
      a1 = word_addr(pool[take_bits(3)]);
      fork
        read_addr(CH_A, a0, 1'b1);
        read_addr(CH_B, a1, 1'b1);
      join
    end

    write_word(word_addr(pool[3]), take_bits(32), 4'hf, 4, 1'b0);
    read_addr(CH_A, word_addr(pool[3]), 1'b0);

    repeat (4) next_cycle();
    if (exp_a.size() + exp_b.size() + exp_bresp.size() + exp_uart.size() != 0) begin
      abort_run("some expected responses never arrived");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
source/axi_memory_pkg.sv
source/byte_store.sv
source/read_port.sv
source/write_port.sv
source/axi_memory.sv
sim/tb_axi_memory.sv

// File: Bender.yml
package:
  name: axi_memory

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/axi_memory_pkg.sv
      - source/byte_store.sv
      - source/read_port.sv
      - source/write_port.sv
      - source/axi_memory.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_axi_memory.sv
